/* source/memPkg.sv */
package memPkg;

  // word and block geometry
  localparam int wordBits = 32;
  localparam int blockWords = 4;
  localparam int blockBits = wordBits * blockWords;

  // 256 blocks in the shared memory
  localparam int blockAddrBits = 8;
  localparam int numBlocks = 2 ** blockAddrBits;

  // memory access timing
  localparam int waitCycles = 2;
  localparam int waitCountBits = $clog2(waitCycles + 1);

  // per-client request FIFO, also the initial credit count
  localparam int bufferDepth = 4;
  localparam int bufPtrBits = $clog2(bufferDepth);
  localparam int bufCountBits = $clog2(bufferDepth + 1);

  // instruction side and data side
  localparam int numClients = 2;

  typedef logic [blockAddrBits-1:0] blockAddrT;
  // word 0 sits in the low bits
  typedef logic [blockBits-1:0] blockDataT;
  typedef logic [0:0] clientIdT;
  typedef logic [waitCountBits-1:0] waitCountT;
  typedef logic [bufPtrBits-1:0] bufPtrT;
  typedef logic [bufCountBits-1:0] bufCountT;

  // block request, data only meaningful for writes
  typedef struct packed {
    logic      write;
    blockAddrT blockAddr;
    blockDataT data;
  } memReqT;

  // read reply
  typedef struct packed {
    blockAddrT blockAddr;
    blockDataT data;
  } memRespT;

  // blockMemory access sequencing
  typedef enum logic [1:0] {
    memIdle,
    memWaiting,
    memDone
  } memStateT;

endpackage

/* source/requestBuffer.sv */
module requestBuffer
  import memPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   reqValid,
  input  memReqT req,
  input  logic   pop,
  output logic   headValid,
  output memReqT head,
  output logic   creditReturn
);

  // entry storage
  memReqT entries [bufferDepth];

  // circular pointers and fill level
  bufPtrT   wrPtr;
  bufPtrT   rdPtr;
  bufCountT count;

  // wrap at bufferDepth
  function automatic bufPtrT nextPtr(input bufPtrT ptr);
    bufPtrT result;
    if (ptr == bufPtrT'(bufferDepth - 1))
    begin
      result = '0;
    end
    else
    begin
      result = ptr + bufPtrT'(1);
    end
    return result;
  endfunction

  // write side
  // client credits bound the fill level to bufferDepth
  always_ff @(posedge clk)
  begin
    if (reqValid)
    begin
      entries[wrPtr] <= req;
    end
  end

  // pointer and occupancy update
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (reqValid)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      // count only moves when exactly one side is active
      case ({reqValid, pop})
        2'b10:
        begin
          count <= count + bufCountT'(1);
        end
        2'b01:
        begin
          count <= count - bufCountT'(1);
        end
        default:
        begin
          count <= count;
        end
      endcase
    end
  end

  // head visible the cycle after the write edge
  assign headValid = (count != '0);
  assign head = entries[rdPtr];

  // one credit back per drained entry
  // high the cycle after the pop edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      creditReturn <= 1'b0;
    end
    else
    begin
      creditReturn <= pop;
    end
  end

endmodule

/* source/memArbiter.sv */
module memArbiter
  import memPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [numClients-1:0] headValid,
  input  memReqT                head0,
  input  memReqT                head1,
  output logic [numClients-1:0] pop,
  output logic                  start,
  output memReqT                cmd,
  input  logic                  done,
  input  blockDataT             rdData,
  output logic [numClients-1:0] respValid,
  output memRespT               resp
);

  // access in flight
  logic busy;

  // client favoured on a tie, 0 after reset
  clientIdT rrPtr;

  // winner of this cycle
  clientIdT grant;

  // details of the access in flight
  clientIdT  owner;
  logic      ownerWrite;
  blockAddrT ownerAddr;

  // round-robin pick
  always_comb
  begin
    if (headValid[0] && headValid[1])
    begin
      grant = rrPtr;
    end
    else if (headValid[1])
    begin
      grant = 1'b1;
    end
    else
    begin
      grant = 1'b0;
    end
  end

  // issue as soon as the memory is free
  assign start = !busy && (headValid != '0);
  assign cmd = (grant == 1'b1) ? head1 : head0;

  // pop the winner's head together with start
  always_comb
  begin
    pop = '0;
    if (start)
    begin
      pop[grant] = 1'b1;
    end
  end

  // busy flag and tie-break pointer
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      rrPtr <= 1'b0;
    end
    else if (start)
    begin
      busy <= 1'b1;
      // the other client wins the next tie
      rrPtr <= ~grant;
    end
    else if (done)
    begin
      // next start may follow in the cycle after done
      busy <= 1'b0;
    end
  end

  // remember who owns the access
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      owner <= grant;
      ownerWrite <= cmd.write;
      ownerAddr <= cmd.blockAddr;
    end
  end

  // route read data back, writes stay silent
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      respValid <= '0;
    end
    else
    begin
      respValid <= '0;
      if (done && !ownerWrite)
      begin
        respValid[owner] <= 1'b1;
      end
    end
  end

  // shared response payload
  always_ff @(posedge clk)
  begin
    if (done && !ownerWrite)
    begin
      resp.blockAddr <= ownerAddr;
      resp.data <= rdData;
    end
  end

endmodule

/* source/blockMemory.sv */
module blockMemory
  import memPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  memReqT    cmd,
  output logic      done,
  output blockDataT rdData
);

  // sequencing
  memStateT  state;
  waitCountT waitCount;

  // block array and its written flags
  blockDataT mem [numBlocks];
  logic [numBlocks-1:0] written;

  // new access taken only from idle
  logic accept;

  assign accept = start && (state == memIdle);

  // idle -> waiting for waitCycles -> done for one cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= memIdle;
      waitCount <= '0;
    end
    else
    begin
      case (state)
        memIdle:
        begin
          waitCount <= '0;
          if (start)
          begin
            state <= memWaiting;
          end
        end
        memWaiting:
        begin
          // last wait cycle reached
          if (waitCount == waitCountT'(waitCycles - 1))
          begin
            state <= memDone;
          end
          else
          begin
            waitCount <= waitCount + waitCountT'(1);
          end
        end
        memDone:
        begin
          state <= memIdle;
        end
        default:
        begin
          state <= memIdle;
        end
      endcase
    end
  end

  // finished access, rdData valid here too
  assign done = (state == memDone);

  // flags start clear, so unwritten blocks read as zero
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      written <= '0;
    end
    else if (accept && cmd.write)
    begin
      written[cmd.blockAddr] <= 1'b1;
    end
  end

  // whole block written at the start edge
  always_ff @(posedge clk)
  begin
    if (accept && cmd.write)
    begin
      mem[cmd.blockAddr] <= cmd.data;
    end
  end

  // read sampled at the start edge, held until done
  always_ff @(posedge clk)
  begin
    if (accept && !cmd.write)
    begin
      rdData <= written[cmd.blockAddr] ? mem[cmd.blockAddr] : '0;
    end
  end

endmodule

/* source/memSubsystem.sv */
module memSubsystem
  import memPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    reqValid0,
  input  logic    reqValid1,
  input  memReqT  req0,
  input  memReqT  req1,
  output logic    creditReturn0,
  output logic    creditReturn1,
  output logic    respValid0,
  output logic    respValid1,
  output memRespT resp
);

  // buffer heads toward the arbiter
  logic [numClients-1:0] headValid;
  logic [numClients-1:0] pop;
  memReqT head0;
  memReqT head1;

  // arbiter to memory
  logic      start;
  memReqT    cmd;
  logic      done;
  blockDataT rdData;

  // per-client response strobes
  logic [numClients-1:0] respValid;

  // client 0, e.g. instruction side
  requestBuffer u_requestBuffer0 (
    .clk          (clk),
    .rst          (rst),
    .reqValid     (reqValid0),
    .req          (req0),
    .pop          (pop[0]),
    .headValid    (headValid[0]),
    .head         (head0),
    .creditReturn (creditReturn0)
  );

  // client 1, e.g. data side
  requestBuffer u_requestBuffer1 (
    .clk          (clk),
    .rst          (rst),
    .reqValid     (reqValid1),
    .req          (req1),
    .pop          (pop[1]),
    .headValid    (headValid[1]),
    .head         (head1),
    .creditReturn (creditReturn1)
  );

  memArbiter u_memArbiter (
    .clk       (clk),
    .rst       (rst),
    .headValid (headValid),
    .head0     (head0),
    .head1     (head1),
    .pop       (pop),
    .start     (start),
    .cmd       (cmd),
    .done      (done),
    .rdData    (rdData),
    .respValid (respValid),
    .resp      (resp)
  );

  // single memory shared by both clients
  blockMemory u_blockMemory (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .cmd    (cmd),
    .done   (done),
    .rdData (rdData)
  );

  assign respValid0 = respValid[0];
  assign respValid1 = respValid[1];

endmodule

/* dv/memRefModel.svh */
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// shadow of the block memory, zero until written
blockDataT shadow [numBlocks];

// expected read replies per client in issue order
memRespT expQ0 [$];
memRespT expQ1 [$];

// same start state as cleared written flags
function automatic void modelInit();
  foreach (shadow[i])
  begin
    shadow[i] = '0;
  end
  expQ0.delete();
  expQ1.delete();
endfunction

// applied at issue time
// one FIFO and one memory keep per-client order
function automatic void modelIssue(input bit client, input memReqT req);
  memRespT expected;
  expected.blockAddr = req.blockAddr;
  expected.data = shadow[req.blockAddr];
  if (req.write)
  begin
    shadow[req.blockAddr] = req.data;
  end
  else if (client)
  begin
    expQ1.push_back(expected);
  end
  else
  begin
    expQ0.push_back(expected);
  end
endfunction

`endif

/* dv/memSubsystemTb.sv */
module memSubsystemTb
  import memPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // requests over all phases set the cycle limit
  localparam int numRequests = 92;
  localparam int cycleLimit = numRequests * (waitCycles + 3) * 2 + 200;
  // longest wait for credits once nothing is pending
  localparam int drainLimit = numClients * bufferDepth * (waitCycles + 2) + 2;

  logic    clk;
  logic    rst;
  logic    reqValid0;
  logic    reqValid1;
  memReqT  req0;
  memReqT  req1;
  logic    creditReturn0;
  logic    creditReturn1;
  logic    respValid0;
  logic    respValid1;
  memRespT resp;

  integer seed;
  int     errors;
  int     cycles;
  // client side credit counters
  int     credits [numClients];
  int     issued;
  int     returned;
  // responses per client in the fairness window
  int     fair [numClients];
  bit     fairOn;
  // send on every free credit instead of a coin flip
  bit     sendAll;
  string  testName;
  // requests each client still has to send
  memReqT pend0 [$];
  memReqT pend1 [$];

  `include "memRefModel.svh"

  memSubsystem u_memSubsystem (
    .clk           (clk),
    .rst           (rst),
    .reqValid0     (reqValid0),
    .reqValid1     (reqValid1),
    .req0          (req0),
    .req1          (req1),
    .creditReturn0 (creditReturn0),
    .creditReturn1 (creditReturn1),
    .respValid0    (respValid0),
    .respValid1    (respValid1),
    .resp          (resp)
  );

  // 100 ns clock
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #50 clk = ~clk;
    end
  end

  // watchdog
  initial
  begin
    cycles = 0;
    while (cycles < cycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, responses or credits never came back", cycles);
    $display("Test failures found");
    $finish;
  end

  task automatic checkResp(input memRespT expected, input memRespT actual);
    if (actual !== expected)
    begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  task automatic checkCredits(input string what, input int expected, input int actual);
    if (actual != expected)
    begin
      errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", testName, what, expected, actual);
    end
  endtask

  // creditReturn1, creditReturn0, respValid1, respValid0
  task automatic checkIdle();
    logic [3:0] actual;
    actual = {creditReturn1, creditReturn0, respValid1, respValid0};
    if (actual !== 4'b0000)
    begin
      errors++;
      $display("FAILED %s idle outputs: expected %b, actual %b", testName, 4'b0000, actual);
    end
  endtask

  function automatic bit coin();
    return 1'($random(seed));
  endfunction

  // client 0 in the low half and client 1 in the high half
  function automatic blockAddrT randomAddr(input bit client);
    blockAddrT addr;
    addr = blockAddrT'($random(seed));
    return {client, addr[6:0]};
  endfunction

  function automatic blockDataT randomData();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic memReqT makeReq(input logic write, input blockAddrT addr,
                                     input blockDataT data);
    memReqT req;
    req.write = write;
    req.blockAddr = addr;
    req.data = write ? data : '0;
    return req;
  endfunction

  function automatic void pushReq(input bit client, input memReqT req);
    if (client)
    begin
      pend1.push_back(req);
    end
    else
    begin
      pend0.push_back(req);
    end
  endfunction

  // one response strobe of one client
  task automatic takeResp(input bit client, input logic valid);
    memRespT expected;
    if (valid)
    begin
      fair[client]++;
      if ((client ? expQ1.size() : expQ0.size()) == 0)
      begin
        errors++;
        $display("%s: client %0d got a response it never asked for", testName, client);
      end
      else
      begin
        expected = client ? expQ1.pop_front() : expQ0.pop_front();
        checkResp(expected, resp);
      end
    end
  endtask

  task automatic sampleOutputs();
    credits[0] += int'(creditReturn0);
    credits[1] += int'(creditReturn1);
    returned += int'(creditReturn0) + int'(creditReturn1);
    if (respValid0 && respValid1)
    begin
      errors++;
      $display("%s: both clients got a response in the same cycle", testName);
    end
    takeResp(1'b0, respValid0);
    takeResp(1'b1, respValid1);
    if (fairOn && (fair[0] > fair[1] + 1 || fair[1] > fair[0] + 1))
    begin
      errors++;
      $display("%s: responses of the two clients stopped interleaving", testName);
    end
    if (credits[0] > bufferDepth || credits[1] > bufferDepth)
    begin
      errors++;
      $display("%s: more credits came back than requests were sent", testName);
    end
  endtask

  // only while a credit is held
  task automatic sendFrom(input bit client);
    memReqT req;
    if ((client ? pend1.size() : pend0.size()) > 0 && credits[client] > 0
        && (sendAll || coin()))
    begin
      req = client ? pend1.pop_front() : pend0.pop_front();
      credits[client]--;
      issued++;
      modelIssue(client, req);
      if (client)
      begin
        reqValid1 = 1'b1;
        req1 = req;
      end
      else
      begin
        reqValid0 = 1'b1;
        req0 = req;
      end
    end
  endtask

  // sample and drive at the falling edge
  task automatic stepCycle();
    @(negedge clk);
    sampleOutputs();
    reqValid0 = 1'b0;
    reqValid1 = 1'b0;
    sendFrom(1'b0);
    sendFrom(1'b1);
  endtask

  task automatic drainAll();
    int waited;
    while (pend0.size() > 0 || pend1.size() > 0 || expQ0.size() > 0 || expQ1.size() > 0)
    begin
      stepCycle();
    end
    // buffered writes still pass the memory one access at a time
    waited = 0;
    while ((credits[0] != bufferDepth || credits[1] != bufferDepth) && waited < drainLimit)
    begin
      stepCycle();
      waited++;
    end
    // a trailing write may still be in the memory
    repeat (waitCycles + 3)
    begin
      stepCycle();
      checkIdle();
    end
    checkCredits("client 0 credits", bufferDepth, credits[0]);
    checkCredits("client 1 credits", bufferDepth, credits[1]);
    checkCredits("credit returns", issued, returned);
  endtask

  initial
  begin
    blockAddrT addr;
    blockAddrT readBack [$];
    seed = 32'h4ce2_0f7b;
    errors = 0;
    issued = 0;
    returned = 0;
    credits[0] = bufferDepth;
    credits[1] = bufferDepth;
    fair[0] = 0;
    fair[1] = 0;
    fairOn = 1'b0;
    sendAll = 1'b0;
    rst = 1'b1;
    reqValid0 = 1'b0;
    reqValid1 = 1'b0;
    req0 = '0;
    req1 = '0;
    modelInit();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // quiet outputs then zero reads of untouched blocks
    testName = "idle after reset";
    repeat (5)
    begin
      stepCycle();
      checkIdle();
    end
    testName = "unwritten read";
    pushReq(1'b0, makeReq(1'b0, randomAddr(1'b0), '0));
    pushReq(1'b1, makeReq(1'b0, randomAddr(1'b1), '0));
    drainAll();

    // 8 writes then reads of the same blocks
    testName = "write and read-back";
    for (int c = 0; c < numClients; c++)
    begin
      for (int i = 0; i < 8; i++)
      begin
        addr = randomAddr(1'(c));
        pushReq(1'(c), makeReq(1'b1, addr, randomData()));
        readBack.push_back(addr);
      end
      foreach (readBack[i])
      begin
        pushReq(1'(c), makeReq(1'b0, readBack[i], '0));
      end
      readBack.delete();
    end
    drainAll();

    // bursts of up to bufferDepth mixed reads and writes
    testName = "credit bursts";
    sendAll = 1'b1;
    for (int i = 0; i < 16; i++)
    begin
      pushReq(1'b0, makeReq(coin(), randomAddr(1'b0), randomData()));
      pushReq(1'b1, makeReq(coin(), randomAddr(1'b1), randomData()));
    end
    drainAll();

    // client 1 reads what client 0 wrote
    testName = "shared region";
    sendAll = 1'b0;
    pushReq(1'b0, makeReq(1'b1, 8'h2a, randomData()));
    drainAll();
    pushReq(1'b1, makeReq(1'b0, 8'h2a, '0));
    drainAll();

    // both clients saturate the arbiter
    testName = "fairness";
    sendAll = 1'b1;
    fair[0] = 0;
    fair[1] = 0;
    fairOn = 1'b1;
    for (int i = 0; i < 12; i++)
    begin
      pushReq(1'b0, makeReq(1'b0, randomAddr(1'b0), '0));
      pushReq(1'b1, makeReq(1'b0, randomAddr(1'b1), '0));
    end
    drainAll();
    fairOn = 1'b0;

    $display("%0d errors, %0d requests, %0d credits returned", errors, issued, returned);
    if (errors == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+dv
source/memPkg.sv
source/requestBuffer.sv
source/memArbiter.sv
source/blockMemory.sv
source/memSubsystem.sv
dv/memSubsystemTb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= memSubsystemTb
RTL_TOP   ?= memSubsystem
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_TEXT ?= All tests passed!
SIM_FLAGS ?= --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
